//--- hdl/attention_defines.svh
`ifndef ATTENTION_DEFINES_SVH
`define ATTENTION_DEFINES_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define ATT_ADDR_W 12
`define ATT_DATA_W 32
`define ATT_DIM_W 16

// --------------------------------------------------
// Dimension word layout
// --------------------------------------------------
// Rows in the upper half, columns in the lower half
`define ATT_ROWS_MSB 31
`define ATT_ROWS_LSB 16
`define ATT_DIMS_ADDR 0

// Wq, Wk and Wv
`define ATT_NUM_PROJ 3

`endif

//--- hdl/attention_pkg.sv
`include "attention_defines.svh"

package attention_pkg;

  typedef logic [`ATT_ADDR_W-1:0] addr_t;
  typedef logic [`ATT_DATA_W-1:0] data_t;
  typedef logic [`ATT_DIM_W-1:0]  dim_t;

  // Top-level run phases
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_DIMS_REQ,
    PH_DIMS_CAPTURE,
    PH_PROJECT,
    PH_SCORE
  } phase_t;

  // Shared by the projection and score engines
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,
    ENG_DRAIN
  } engine_state_t;

endpackage

//--- hdl/mac_unit.sv
`timescale 1ns/100ps

module mac_unit (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 valid,
  input  logic                 first,
  input  attention_pkg::data_t a,
  input  attention_pkg::data_t b,
  output attention_pkg::data_t acc,
  output logic                 acc_valid
);

  import attention_pkg::*;

  data_t prod_q;
  logic  valid_q;
  logic  first_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      valid_q   <= 1'b0;
      acc_valid <= 1'b0;
    end
    else
    begin
      valid_q   <= valid;
      acc_valid <= valid_q;
    end
  end

  // Stage one multiplies, stage two loads or accumulates
  always_ff @(posedge clk)
  begin
    prod_q  <= a * b;
    first_q <= first;
    if (valid_q)
      acc <= first_q ? prod_q : acc + prod_q;
  end

endmodule

//--- hdl/projection_engine.sv
`timescale 1ns/100ps
`include "attention_defines.svh"

module projection_engine (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  attention_pkg::dim_t   rows_n,
  input  attention_pkg::dim_t   cols_e,
  input  attention_pkg::dim_t   cols_d,
  output attention_pkg::addr_t  input_read_address,
  input  attention_pkg::data_t  input_read_data,
  output attention_pkg::addr_t  weight_read_address,
  input  attention_pkg::data_t  weight_read_data,
  output logic                  wr_enable,
  output attention_pkg::addr_t  wr_address,
  output attention_pkg::data_t  wr_data,
  output logic                  scratchpad_write_enable,
  output attention_pkg::addr_t  scratchpad_write_address,
  output attention_pkg::data_t  scratchpad_write_data,
  output logic                  done
);

  import attention_pkg::*;

  engine_state_t state;
  dim_t          m_idx;
  dim_t          r_idx;
  dim_t          c_idx;
  dim_t          k_idx;
  logic          issue;
  logic          term_last;
  logic          final_term;
  addr_t         nd_size;

  // Term flags aligned with the read data at the MAC input
  logic          valid_q;
  logic          first_q;

  // Per-read tags, index 2 lines up with the accumulator output
  logic [2:0]    last_q;
  logic [2:0]    kcopy_q;
  logic [2:0]    final_q;
  addr_t         dest_q [3];

  data_t         acc;
  logic          acc_valid;

  // --------------------------------------------------
  // Loop control
  // --------------------------------------------------
  assign issue      = (state == ENG_RUN);
  assign term_last  = (k_idx == cols_e - 1'b1);
  assign final_term = term_last && (c_idx == cols_d - 1'b1) &&
                      (r_idx == rows_n - 1'b1) &&
                      (m_idx == dim_t'(`ATT_NUM_PROJ - 1));
  assign nd_size    = addr_t'(rows_n * cols_d);

  // I row-major from 1, each W column-major from 1
  assign input_read_address  = addr_t'(1 + r_idx * cols_e + k_idx);
  assign weight_read_address = addr_t'(1 + (m_idx * cols_d + c_idx) * cols_e + k_idx);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= ENG_IDLE;
      m_idx <= '0;
      r_idx <= '0;
      c_idx <= '0;
      k_idx <= '0;
    end
    else
    begin
      case (state)
        ENG_IDLE:
        begin
          if (start)
          begin
            state <= ENG_RUN;
            m_idx <= '0;
            r_idx <= '0;
            c_idx <= '0;
            k_idx <= '0;
          end
        end
        ENG_RUN:
        begin
          if (final_term)
            state <= ENG_DRAIN;
          // Term, then column, then row, then matrix
          if (!term_last)
            k_idx <= k_idx + 1'b1;
          else
          begin
            k_idx <= '0;
            if (c_idx != cols_d - 1'b1)
              c_idx <= c_idx + 1'b1;
            else
            begin
              c_idx <= '0;
              if (r_idx != rows_n - 1'b1)
                r_idx <= r_idx + 1'b1;
              else
              begin
                r_idx <= '0;
                m_idx <= m_idx + 1'b1;
              end
            end
          end
        end
        ENG_DRAIN:
        begin
          if (wr_enable && final_q[2])
            state <= ENG_IDLE;
        end
        default:
          state <= ENG_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Destination delay line
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      valid_q <= 1'b0;
      last_q  <= '0;
      final_q <= '0;
      done    <= 1'b0;
    end
    else
    begin
      valid_q <= issue;
      last_q  <= {last_q[1:0], issue && term_last};
      final_q <= {final_q[1:0], issue && final_term};
      done    <= wr_enable && final_q[2];
    end
  end

  always_ff @(posedge clk)
  begin
    first_q   <= (k_idx == '0);
    kcopy_q   <= {kcopy_q[1:0], m_idx == dim_t'(1)};
    dest_q[0] <= addr_t'(m_idx * nd_size + r_idx * cols_d + c_idx);
    dest_q[1] <= dest_q[0];
    dest_q[2] <= dest_q[1];
  end

  mac_unit u_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .valid     (valid_q),
    .first     (first_q),
    .a         (input_read_data),
    .b         (weight_read_data),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

  // --------------------------------------------------
  // Result and K copy writes
  // --------------------------------------------------
  assign wr_enable  = acc_valid && last_q[2];
  assign wr_address = dest_q[2];
  assign wr_data    = acc;

  // K sits one n*d block into the result SRAM, at 0 in the scratchpad
  assign scratchpad_write_enable  = wr_enable && kcopy_q[2];
  assign scratchpad_write_address = wr_address - nd_size;
  assign scratchpad_write_data    = acc;

  a_write_while_active: assert property (@(posedge clk) disable iff (!reset_n)
    wr_enable |-> (state == ENG_RUN || state == ENG_DRAIN));

endmodule

//--- hdl/score_engine.sv
`timescale 1ns/100ps
`include "attention_defines.svh"

module score_engine (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  start,
  input  attention_pkg::dim_t   rows_n,
  input  attention_pkg::dim_t   cols_d,
  output attention_pkg::addr_t  result_read_address,
  input  attention_pkg::data_t  result_read_data,
  output attention_pkg::addr_t  scratchpad_read_address,
  input  attention_pkg::data_t  scratchpad_read_data,
  output logic                  wr_enable,
  output attention_pkg::addr_t  wr_address,
  output attention_pkg::data_t  wr_data,
  output logic                  done
);

  import attention_pkg::*;

  engine_state_t state;
  dim_t          i_idx;
  dim_t          j_idx;
  dim_t          k_idx;
  logic          issue;
  logic          term_last;
  logic          final_term;
  addr_t         s_base;

  logic          valid_q;
  logic          first_q;
  logic [2:0]    last_q;
  logic [2:0]    final_q;
  addr_t         dest_q [3];

  data_t         acc;
  logic          acc_valid;

  // --------------------------------------------------
  // Loop control
  // --------------------------------------------------
  assign issue      = (state == ENG_RUN);
  assign term_last  = (k_idx == cols_d - 1'b1);
  assign final_term = term_last && (j_idx == rows_n - 1'b1) && (i_idx == rows_n - 1'b1);

  // S follows Q, K and V in the result SRAM
  assign s_base = addr_t'(`ATT_NUM_PROJ * rows_n * cols_d);

  // Q row i from the result SRAM, K row j from the scratchpad
  assign result_read_address     = addr_t'(i_idx * cols_d + k_idx);
  assign scratchpad_read_address = addr_t'(j_idx * cols_d + k_idx);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= ENG_IDLE;
      i_idx <= '0;
      j_idx <= '0;
      k_idx <= '0;
    end
    else
    begin
      case (state)
        ENG_IDLE:
        begin
          if (start)
          begin
            state <= ENG_RUN;
            i_idx <= '0;
            j_idx <= '0;
            k_idx <= '0;
          end
        end
        ENG_RUN:
        begin
          if (final_term)
            state <= ENG_DRAIN;
          if (!term_last)
            k_idx <= k_idx + 1'b1;
          else
          begin
            k_idx <= '0;
            if (j_idx != rows_n - 1'b1)
              j_idx <= j_idx + 1'b1;
            else
            begin
              j_idx <= '0;
              i_idx <= i_idx + 1'b1;
            end
          end
        end
        ENG_DRAIN:
        begin
          if (wr_enable && final_q[2])
            state <= ENG_IDLE;
        end
        default:
          state <= ENG_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // Destination delay line and MAC
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      valid_q <= 1'b0;
      last_q  <= '0;
      final_q <= '0;
      done    <= 1'b0;
    end
    else
    begin
      valid_q <= issue;
      last_q  <= {last_q[1:0], issue && term_last};
      final_q <= {final_q[1:0], issue && final_term};
      done    <= wr_enable && final_q[2];
    end
  end

  always_ff @(posedge clk)
  begin
    first_q   <= (k_idx == '0);
    dest_q[0] <= addr_t'(s_base + i_idx * rows_n + j_idx);
    dest_q[1] <= dest_q[0];
    dest_q[2] <= dest_q[1];
  end

  mac_unit u_mac (
    .clk       (clk),
    .reset_n   (reset_n),
    .valid     (valid_q),
    .first     (first_q),
    .a         (result_read_data),
    .b         (scratchpad_read_data),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

  assign wr_enable  = acc_valid && last_q[2];
  assign wr_address = dest_q[2];
  assign wr_data    = acc;

endmodule

//--- hdl/attention_sequencer.sv
`timescale 1ns/100ps
`include "attention_defines.svh"

module attention_sequencer (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  dut_valid,
  output logic                  dut_ready,
  input  attention_pkg::data_t  dims_input_word,
  input  attention_pkg::data_t  dims_weight_word,
  output logic                  dims_read,
  output attention_pkg::dim_t   rows_n,
  output attention_pkg::dim_t   cols_e,
  output attention_pkg::dim_t   cols_d,
  output logic                  proj_start,
  input  logic                  proj_done,
  output logic                  score_start,
  input  logic                  score_done,
  input  logic                  proj_wr_enable,
  input  attention_pkg::addr_t  proj_wr_address,
  input  attention_pkg::data_t  proj_wr_data,
  input  logic                  score_wr_enable,
  input  attention_pkg::addr_t  score_wr_address,
  input  attention_pkg::data_t  score_wr_data,
  output logic                  result_write_enable,
  output attention_pkg::addr_t  result_write_address,
  output attention_pkg::data_t  result_write_data
);

  import attention_pkg::*;

  phase_t phase;

  // --------------------------------------------------
  // Phase FSM
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      phase       <= PH_IDLE;
      proj_start  <= 1'b0;
      score_start <= 1'b0;
    end
    else
    begin
      proj_start  <= (phase == PH_DIMS_CAPTURE);
      score_start <= (phase == PH_PROJECT) && proj_done;
      case (phase)
        PH_IDLE:
        begin
          if (dut_valid)
            phase <= PH_DIMS_REQ;
        end
        PH_DIMS_REQ:
          phase <= PH_DIMS_CAPTURE;
        PH_DIMS_CAPTURE:
          phase <= PH_PROJECT;
        PH_PROJECT:
        begin
          if (proj_done)
            phase <= PH_SCORE;
        end
        PH_SCORE:
        begin
          if (score_done)
            phase <= PH_IDLE;
        end
        default:
          phase <= PH_IDLE;
      endcase
    end
  end

  assign dut_ready = (phase == PH_IDLE);

  // Address 0 goes out in the request cycle, the words return one cycle later
  assign dims_read = (phase == PH_DIMS_REQ);

  always_ff @(posedge clk)
  begin
    if (phase == PH_DIMS_CAPTURE)
    begin
      rows_n <= dims_input_word[`ATT_ROWS_MSB:`ATT_ROWS_LSB];
      cols_e <= dims_input_word[`ATT_DIM_W-1:0];
      cols_d <= dims_weight_word[`ATT_DIM_W-1:0];
    end
  end

  // --------------------------------------------------
  // Result SRAM write port
  // --------------------------------------------------
  assign result_write_enable  = (phase == PH_PROJECT) ? proj_wr_enable :
                                (phase == PH_SCORE)   ? score_wr_enable : 1'b0;
  assign result_write_address = (phase == PH_SCORE) ? score_wr_address : proj_wr_address;
  assign result_write_data    = (phase == PH_SCORE) ? score_wr_data : proj_wr_data;

  // Inner dimensions of I and each W must agree
  a_dims_match: assert property (@(posedge clk) disable iff (!reset_n)
    (phase == PH_DIMS_CAPTURE) |->
      (dims_weight_word[`ATT_ROWS_MSB:`ATT_ROWS_LSB] == dims_input_word[`ATT_DIM_W-1:0]));

  a_no_score_write_in_project: assert property (@(posedge clk) disable iff (!reset_n)
    (phase == PH_PROJECT) |-> !score_wr_enable);

  a_no_proj_write_in_score: assert property (@(posedge clk) disable iff (!reset_n)
    (phase == PH_SCORE) |-> !proj_wr_enable);

endmodule

//--- hdl/attention_top.sv
`timescale 1ns/100ps
`include "attention_defines.svh"

module attention_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  dut_valid,
  output logic                  dut_ready,
  output attention_pkg::addr_t  input_read_address,
  input  attention_pkg::data_t  input_read_data,
  output attention_pkg::addr_t  weight_read_address,
  input  attention_pkg::data_t  weight_read_data,
  output logic                  result_write_enable,
  output attention_pkg::addr_t  result_write_address,
  output attention_pkg::data_t  result_write_data,
  output attention_pkg::addr_t  result_read_address,
  input  attention_pkg::data_t  result_read_data,
  output logic                  scratchpad_write_enable,
  output attention_pkg::addr_t  scratchpad_write_address,
  output attention_pkg::data_t  scratchpad_write_data,
  output attention_pkg::addr_t  scratchpad_read_address,
  input  attention_pkg::data_t  scratchpad_read_data
);

  import attention_pkg::*;

  logic  dims_read;
  dim_t  rows_n;
  dim_t  cols_e;
  dim_t  cols_d;
  logic  proj_start;
  logic  proj_done;
  logic  score_start;
  logic  score_done;
  addr_t proj_input_address;
  addr_t proj_weight_address;
  logic  proj_wr_enable;
  addr_t proj_wr_address;
  data_t proj_wr_data;
  logic  score_wr_enable;
  addr_t score_wr_address;
  data_t score_wr_data;

  // Dimension words live at the same address in both SRAMs
  assign input_read_address  = dims_read ? addr_t'(`ATT_DIMS_ADDR) : proj_input_address;
  assign weight_read_address = dims_read ? addr_t'(`ATT_DIMS_ADDR) : proj_weight_address;

  attention_sequencer u_sequencer (
    .clk                  (clk),
    .reset_n              (reset_n),
    .dut_valid            (dut_valid),
    .dut_ready            (dut_ready),
    .dims_input_word      (input_read_data),
    .dims_weight_word     (weight_read_data),
    .dims_read            (dims_read),
    .rows_n               (rows_n),
    .cols_e               (cols_e),
    .cols_d               (cols_d),
    .proj_start           (proj_start),
    .proj_done            (proj_done),
    .score_start          (score_start),
    .score_done           (score_done),
    .proj_wr_enable       (proj_wr_enable),
    .proj_wr_address      (proj_wr_address),
    .proj_wr_data         (proj_wr_data),
    .score_wr_enable      (score_wr_enable),
    .score_wr_address     (score_wr_address),
    .score_wr_data        (score_wr_data),
    .result_write_enable  (result_write_enable),
    .result_write_address (result_write_address),
    .result_write_data    (result_write_data)
  );

  projection_engine u_projection (
    .clk                      (clk),
    .reset_n                  (reset_n),
    .start                    (proj_start),
    .rows_n                   (rows_n),
    .cols_e                   (cols_e),
    .cols_d                   (cols_d),
    .input_read_address       (proj_input_address),
    .input_read_data          (input_read_data),
    .weight_read_address      (proj_weight_address),
    .weight_read_data         (weight_read_data),
    .wr_enable                (proj_wr_enable),
    .wr_address               (proj_wr_address),
    .wr_data                  (proj_wr_data),
    .scratchpad_write_enable  (scratchpad_write_enable),
    .scratchpad_write_address (scratchpad_write_address),
    .scratchpad_write_data    (scratchpad_write_data),
    .done                     (proj_done)
  );

  score_engine u_score (
    .clk                     (clk),
    .reset_n                 (reset_n),
    .start                   (score_start),
    .rows_n                  (rows_n),
    .cols_d                  (cols_d),
    .result_read_address     (result_read_address),
    .result_read_data        (result_read_data),
    .scratchpad_read_address (scratchpad_read_address),
    .scratchpad_read_data    (scratchpad_read_data),
    .wr_enable               (score_wr_enable),
    .wr_address              (score_wr_address),
    .wr_data                 (score_wr_data),
    .done                    (score_done)
  );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
  end

  // Free-running, first rising edge at half a period
  always
  begin
    #(PERIOD_NS / 2);
    clk = ~clk;
  end

endmodule

//--- verification/attention_tb.sv
`timescale 1ns/100ps
`include "attention_defines.svh"

module attention_tb;

  import attention_pkg::*;

  localparam int MEM_DEPTH = 1 << `ATT_ADDR_W;

  logic  clk;
  logic  reset_n = 1'b0;
  logic  dut_valid = 1'b0;
  logic  dut_ready;
  addr_t input_read_address;
  addr_t weight_read_address;
  addr_t result_read_address;
  addr_t scratchpad_read_address;
  data_t input_read_data = '0;
  data_t weight_read_data = '0;
  data_t result_read_data = '0;
  data_t scratchpad_read_data = '0;
  logic  result_write_enable;
  addr_t result_write_address;
  data_t result_write_data;
  logic  scratchpad_write_enable;
  addr_t scratchpad_write_address;
  data_t scratchpad_write_data;

  // SRAM arrays and the address registers behind their read ports
  data_t input_mem [0:MEM_DEPTH-1];
  data_t weight_mem [0:MEM_DEPTH-1];
  data_t result_mem [0:MEM_DEPTH-1];
  data_t scratch_mem [0:MEM_DEPTH-1];
  addr_t input_addr_q = '0;
  addr_t weight_addr_q = '0;
  addr_t result_addr_q = '0;
  addr_t scratch_addr_q = '0;
  logic  clear_mem = 1'b0;
  int    result_writes = 0;
  int    scratch_writes = 0;

  // Stimulus matrices and expected memory images
  data_t i_vals [0:7][0:7];
  data_t w_vals [0:2][0:7][0:7];
  data_t exp_result [0:MEM_DEPTH-1];
  data_t exp_scratch [0:MEM_DEPTH-1];

  // Compare request and per-run mismatch counts
  logic  check_pending = 1'b0;
  int    cur_n;
  int    cur_d;
  int    proj_errs;
  int    kcopy_errs;
  int    score_errs;
  int    flow_errs;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    error_total = 0;
  int    cycle_count = 0;

  tb_clock_gen #(.PERIOD_NS(20)) u_clock (.clk(clk));

  attention_top dut_i (.*);

  // --------------------------------------------------
  // SRAM models, one cycle read latency
  // --------------------------------------------------
  always @(posedge clk)
  begin
    input_addr_q   <= input_read_address;
    weight_addr_q  <= weight_read_address;
    result_addr_q  <= result_read_address;
    scratch_addr_q <= scratchpad_read_address;
  end

  always @(negedge clk)
  begin
    input_read_data      <= input_mem[input_addr_q];
    weight_read_data     <= weight_mem[weight_addr_q];
    result_read_data     <= result_mem[result_addr_q];
    scratchpad_read_data <= scratch_mem[scratch_addr_q];
  end

  always @(posedge clk)
  begin
    if (clear_mem)
    begin
      for (int a = 0; a < MEM_DEPTH; a++)
      begin
        result_mem[a]  <= fill_word(8'hc0, a);
        scratch_mem[a] <= fill_word(8'h5c, a);
      end
      result_writes  <= 0;
      scratch_writes <= 0;
    end
    else
    begin
      if (result_write_enable)
      begin
        result_mem[result_write_address] <= result_write_data;
        result_writes <= result_writes + 1;
      end
      if (scratchpad_write_enable)
      begin
        scratch_mem[scratchpad_write_address] <= scratchpad_write_data;
        scratch_writes <= scratch_writes + 1;
      end
    end
  end

  function automatic data_t fill_word(input logic [7:0] tag, input int a);
    addr_t adr;
    adr = addr_t'(a);
    return {tag, ~adr, adr};
  endfunction

  function automatic string matrix_label(input int m);
    if (m == 0)
      return "Q";
    else if (m == 1)
      return "K";
    return "V";
  endfunction

  function automatic int cycle_budget(input int n, input int e, input int d);
    return 3 * n * d * (e + 2) + n * n * (d + 2) + 20;
  endfunction

  function automatic data_t next_value(input bit wide);
    data_t v;
    if (wide)
      v = $urandom;
    else
    begin
      // Small signed values in -8..8
      v = $urandom % 17;
      v = v - 8;
    end
    return v;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic void attention_ref(input int n, input int e, input int d);
    data_t sum;
    for (int m = 0; m < 3; m++)
      for (int r = 0; r < n; r++)
        for (int c = 0; c < d; c++)
        begin
          sum = '0;
          for (int k = 0; k < e; k++)
            sum = sum + i_vals[r][k] * w_vals[m][k][c];
          exp_result[m * n * d + r * d + c] = sum;
          if (m == 1)
            exp_scratch[r * d + c] = sum;
        end
    // S = Q times K transposed
    for (int i = 0; i < n; i++)
      for (int j = 0; j < n; j++)
      begin
        sum = '0;
        for (int k = 0; k < d; k++)
          sum = sum + exp_result[i * d + k] * exp_result[n * d + j * d + k];
        exp_result[3 * n * d + i * n + j] = sum;
      end
  endfunction

  task automatic load_memories(input int n, input int e, input int d);
    for (int a = 0; a < MEM_DEPTH; a++)
    begin
      input_mem[a]  = fill_word(8'h1a, a);
      weight_mem[a] = fill_word(8'h3b, a);
    end
    input_mem[`ATT_DIMS_ADDR]  = {n[`ATT_DIM_W-1:0], e[`ATT_DIM_W-1:0]};
    weight_mem[`ATT_DIMS_ADDR] = {e[`ATT_DIM_W-1:0], d[`ATT_DIM_W-1:0]};
    for (int r = 0; r < n; r++)
      for (int k = 0; k < e; k++)
        input_mem[1 + r * e + k] = i_vals[r][k];
    // Each W column-major
    for (int m = 0; m < 3; m++)
      for (int c = 0; c < d; c++)
        for (int k = 0; k < e; k++)
          weight_mem[1 + m * d * e + c * e + k] = w_vals[m][k][c];
  endtask

  // --------------------------------------------------
  // Compare process
  // --------------------------------------------------
  initial
  begin : compare_proc
    int    nd;
    int    m;
    string loc;
    forever
    begin
      wait (check_pending);
      nd = cur_n * cur_d;
      for (int a = 0; a < 3 * nd; a++)
      begin
        m = a / nd;
        loc = $sformatf("%s result_mem[%0d]", matrix_label(m), a);
        assert (result_mem[a] === exp_result[a])
        else
        begin
          $display("FAILED %s expected %h actual %h", loc, exp_result[a], result_mem[a]);
          proj_errs++;
        end
      end
      for (int a = 0; a < nd; a++)
      begin
        assert (scratch_mem[a] === exp_scratch[a])
        else
        begin
          $display("FAILED K copy scratch_mem[%0d] expected %h actual %h",
                   a, exp_scratch[a], scratch_mem[a]);
          kcopy_errs++;
        end
      end
      for (int a = 3 * nd; a < 3 * nd + cur_n * cur_n; a++)
      begin
        assert (result_mem[a] === exp_result[a])
        else
        begin
          $display("FAILED S result_mem[%0d] expected %h actual %h",
                   a, exp_result[a], result_mem[a]);
          score_errs++;
        end
      end
      // Exactly one set of results per run
      assert (result_writes == 3 * nd + cur_n * cur_n)
      else
      begin
        $display("FAILED result_writes expected %h actual %h",
                 3 * nd + cur_n * cur_n, result_writes);
        flow_errs++;
      end
      assert (scratch_writes == nd)
      else
      begin
        $display("FAILED scratch_writes expected %h actual %h", nd, scratch_writes);
        flow_errs++;
      end
      check_pending = 1'b0;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic run_case(input int n, input int e, input int d, input bit wide,
                          input bit busy_pulse);
    proj_errs  = 0;
    kcopy_errs = 0;
    score_errs = 0;
    flow_errs  = 0;
    for (int r = 0; r < n; r++)
      for (int k = 0; k < e; k++)
        i_vals[r][k] = next_value(wide);
    for (int m = 0; m < 3; m++)
      for (int k = 0; k < e; k++)
        for (int c = 0; c < d; c++)
          w_vals[m][k][c] = next_value(wide);
    load_memories(n, e, d);
    attention_ref(n, e, d);
    clear_mem = 1'b1;
    @(negedge clk);
    clear_mem = 1'b0;
    assert (dut_ready)
    else
    begin
      $display("DUT was not ready when a run was requested");
      flow_errs++;
    end
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    if (busy_pulse)
    begin
      repeat (4) @(negedge clk);
      assert (!dut_ready)
      else
      begin
        $display("dut_ready went high before the run could have finished");
        flow_errs++;
      end
      // Must be ignored while busy
      dut_valid = 1'b1;
      @(negedge clk);
      dut_valid = 1'b0;
    end
    while (!dut_ready)
      @(negedge clk);
    if (busy_pulse)
    begin
      repeat (2)
      begin
        @(negedge clk);
        assert (dut_ready)
        else
        begin
          $display("dut_ready dropped again, so the busy valid started a run");
          flow_errs++;
        end
      end
    end
    cur_n = n;
    cur_d = d;
    check_pending = 1'b1;
    wait (!check_pending);
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    error_total += errs;
    if (errs != 0)
      tests_failed++;
    $display("Test %-14s %s (%0d mismatches)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  initial
  begin : main_proc
    int errs;
    void'($urandom(49939));
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);

    errs = 0;
    assert (dut_ready === 1'b1)
    else
    begin
      $display("FAILED dut_ready expected %h actual %h", 1'b1, dut_ready);
      errs++;
    end
    assert (result_write_enable === 1'b0 && scratchpad_write_enable === 1'b0)
    else
    begin
      $display("FAILED write enables expected %h actual %h", 2'b00,
               {result_write_enable, scratchpad_write_enable});
      errs++;
    end
    report_test("reset_state", errs);

    run_case(3, 4, 2, 1'b0, 1'b0);
    report_test("projections", proj_errs + flow_errs);
    report_test("k_copy", kcopy_errs);
    report_test("scores", score_errs);

    run_case(2, 3, 4, 1'b0, 1'b1);
    errs = proj_errs + kcopy_errs + score_errs + flow_errs;
    run_case(4, 2, 3, 1'b0, 1'b0);
    errs += proj_errs + kcopy_errs + score_errs + flow_errs;
    report_test("back_to_back", errs);

    run_case(1, 1, 1, 1'b0, 1'b0);
    report_test("unit_size", proj_errs + kcopy_errs + score_errs + flow_errs);
    run_case(2, 3, 2, 1'b1, 1'b0);
    report_test("wrap_32bit", proj_errs + kcopy_errs + score_errs + flow_errs);

    $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, error_total);
    if (tests_failed == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  initial
  begin : watchdog
    int limit;
    limit = 2 * (cycle_budget(3, 4, 2) + cycle_budget(2, 3, 4) + cycle_budget(4, 2, 3) +
                 cycle_budget(1, 1, 1) + cycle_budget(2, 3, 2));
    while (cycle_count < limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles without all runs completing", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/attention_pkg.sv
hdl/mac_unit.sv
hdl/projection_engine.sv
hdl/score_engine.sv
hdl/attention_sequencer.sv
hdl/attention_top.sv
verification/tb_clock_gen.sv
verification/attention_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := attention_tb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
